// File: design/dl_pkg.sv
/*
 * Shared widths, timing and encodings for the ROM download path.
 * Every design file refers to these by scoped name (dl_pkg::name).
 */
package dl_pkg;

    // Host side of the download
    localparam int dl_addr_w = 27;
    localparam int dl_data_w = 16;
    localparam int index_w   = 8;

    // Byte side toward ROM and the configuration registers
    localparam int rom_addr_w = 25;
    localparam int byte_w     = 8;

    // Cycles between the low and the high byte write of one host word
    localparam int gap_cnt_w = 5;
    localparam logic [gap_cnt_w-1:0] dwnld_gap = 5'd24;

    // DIP switches, loaded a byte at a time
    localparam int dip_bytes = 4;
    localparam int dip_sel_w = $clog2(dip_bytes);
    localparam int dipsw_w   = dip_bytes * byte_w;
    localparam logic [dipsw_w-1:0] dipsw_rst = '1;

    // Core mode register
    localparam int core_mod_w = 7;
    localparam logic [core_mod_w-1:0] core_mod_rst = 7'd1;

    // Download index values used by the host
    typedef enum logic [index_w-1:0] {
        idx_rom      = 8'd0,
        idx_core_mod = 8'd1,
        idx_dipsw    = 8'd254
    } ioctl_index_e;

    // Word splitter FSM
    typedef enum logic {
        split_idle,
        split_wait
    } split_state_e;

endpackage

// File: design/ioctl_if.sv
/*
 * Byte write bus from the word splitter to its consumers.
 * One write per cycle in which wr is high; addr, data and index
 * are valid in that same cycle. Consumers always accept.
 */
interface ioctl_if;

    // Write strobe, one cycle per byte
    logic wr;

    // Byte address toward ROM, bit 0 selects the half of the host word
    logic [dl_pkg::rom_addr_w-1:0] addr;

    logic [dl_pkg::byte_w-1:0] data;

    // Download index of the file in progress
    dl_pkg::ioctl_index_e index;

    // Splitter side
    modport src (
        output wr,
        output addr,
        output data,
        output index
    );

    // Router and configuration store
    modport dst (
        input wr,
        input addr,
        input data,
        input index
    );

endinterface

// File: design/dwnld_split.sv
/*
 * Splits each 16-bit host download word into two byte writes.
 * The low byte goes out the cycle after the host strobe, the high
 * byte dwnld_gap cycles later, giving downstream time per byte.
 */
module dwnld_split (
    input  logic                         clk_rom,
    input  logic                         rst,
    input  logic                         dl_wr,
    input  logic [dl_pkg::dl_addr_w-1:0] dl_addr,
    input  logic [dl_pkg::dl_data_w-1:0] dl_data,
    input  logic [dl_pkg::index_w-1:0]   dl_index,
    ioctl_if.src                         byte_bus
);

    dl_pkg::split_state_e               state;
    logic [dl_pkg::gap_cnt_w-1:0]       cnt;
    logic [dl_pkg::byte_w-1:0]          hi_byte;
    logic [dl_pkg::rom_addr_w-2:0]      word_addr;
    logic                               hi_due;

    // Last cycle of the gap, high byte goes out on the next edge
    assign hi_due = (state == dl_pkg::split_wait) && (cnt == dl_pkg::gap_cnt_w'(1));

    // Index is held by the host for the whole download
    assign byte_bus.index = dl_pkg::ioctl_index_e'(dl_index);

    // FSM and write strobe
    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            state       <= dl_pkg::split_idle;
            cnt         <= '0;
            byte_bus.wr <= 1'b0;
        end else begin
            byte_bus.wr <= dl_wr || hi_due;
            if (dl_wr) begin
                state <= dl_pkg::split_wait;
                cnt   <= dl_pkg::dwnld_gap;
            end else if (state == dl_pkg::split_wait) begin
                // Stays busy through the cycle the high byte is on the bus
                if (cnt == '0) begin
                    state <= dl_pkg::split_idle;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    // Byte payload and the pending high half
    always_ff @(posedge clk_rom) begin
        if (dl_wr) begin
            hi_byte       <= dl_data[dl_pkg::dl_data_w-1:dl_pkg::byte_w];
            word_addr     <= dl_addr[dl_pkg::rom_addr_w-1:1];
            byte_bus.addr <= {dl_addr[dl_pkg::rom_addr_w-1:1], 1'b0};
            byte_bus.data <= dl_data[dl_pkg::byte_w-1:0];
        end else if (hi_due) begin
            byte_bus.addr <= {word_addr, 1'b1};
            byte_bus.data <= hi_byte;
        end
    end

    // Host must leave room for the high byte before the next word
    a_no_strobe_in_wait: assert property (
        @(posedge clk_rom) disable iff (rst)
        dl_wr |-> (state == dl_pkg::split_idle)
    ) else $error("host download strobe while the previous word is pending");

    // Two byte writes never touch each other
    a_wr_spaced: assert property (
        @(posedge clk_rom) disable iff (rst)
        byte_bus.wr |=> !byte_bus.wr
    ) else $error("byte writes in adjacent cycles");

endmodule

// File: design/ioctl_router.sv
/*
 * Routes index-0 byte writes to the ROM write port and keeps the
 * downloading flag. Both are registered one cycle after their inputs.
 * Writes for other indices are left to the configuration store.
 */
module ioctl_router (
    input  logic                          clk_rom,
    input  logic                          rst,
    input  logic                          dl_active,
    input  logic [dl_pkg::index_w-1:0]    dl_index,
    ioctl_if.dst                          byte_bus,
    output logic                          rom_wr,
    output logic [dl_pkg::rom_addr_w-1:0] rom_addr,
    output logic [dl_pkg::byte_w-1:0]     rom_data,
    output logic                          downloading
);

    logic rom_dl;
    logic rom_hit;

    // Host is sending a ROM file right now
    assign rom_dl = dl_active && (dl_index == dl_pkg::idx_rom);

    // Byte writes reach the ROM port only while the flag is up
    assign rom_hit = byte_bus.wr && (byte_bus.index == dl_pkg::idx_rom) && downloading;

    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            rom_wr      <= 1'b0;
            downloading <= 1'b0;
        end else begin
            rom_wr      <= rom_hit;
            downloading <= rom_dl;
        end
    end

    // Address and data only matter while rom_wr is high
    always_ff @(posedge clk_rom) begin
        if (rom_hit) begin
            rom_addr <= byte_bus.addr;
            rom_data <= byte_bus.data;
        end
    end

    // ROM port only writes during a ROM download
    a_wr_in_download: assert property (
        @(posedge clk_rom) disable iff (rst)
        rom_wr |-> downloading
    ) else $error("ROM write outside of a ROM download");

endmodule

// File: design/cfg_store.sv
/*
 * Configuration loaded through the download channel.
 * Index 254 fills the four DIP switch bytes, byte 0 at address 0.
 * Index 1 loads the core mode register from even addresses only,
 * so the high half of a host word cannot overwrite the low half.
 */
module cfg_store (
    input  logic                          clk_rom,
    input  logic                          rst,
    ioctl_if.dst                          byte_bus,
    output logic [dl_pkg::dipsw_w-1:0]    dipsw,
    output logic [dl_pkg::core_mod_w-1:0] core_mod
);

    logic [dl_pkg::byte_w-1:0] dsw [dl_pkg::dip_bytes];
    logic                      dip_hit;
    logic                      mod_hit;
    logic [dl_pkg::dip_sel_w-1:0] dip_sel;

    // Only the first four addresses of the DIP file are kept
    assign dip_hit = byte_bus.wr && (byte_bus.index == dl_pkg::idx_dipsw)
                     && (byte_bus.addr[dl_pkg::rom_addr_w-1:dl_pkg::dip_sel_w] == '0);

    assign dip_sel = byte_bus.addr[dl_pkg::dip_sel_w-1:0];

    // Odd address is the high half of the host word
    assign mod_hit = byte_bus.wr && (byte_bus.index == dl_pkg::idx_core_mod)
                     && !byte_bus.addr[0];

    // DIP bytes
    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < dl_pkg::dip_bytes; i++) begin
                dsw[i] <= dl_pkg::dipsw_rst[i*dl_pkg::byte_w +: dl_pkg::byte_w];
            end
        end else if (dip_hit) begin
            dsw[dip_sel] <= byte_bus.data;
        end
    end

    // Byte 0 is least significant
    always_comb begin
        for (int i = 0; i < dl_pkg::dip_bytes; i++) begin
            dipsw[i*dl_pkg::byte_w +: dl_pkg::byte_w] = dsw[i];
        end
    end

    // Core mode register
    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            core_mod <= dl_pkg::core_mod_rst;
        end else if (mod_hit) begin
            core_mod <= byte_bus.data[dl_pkg::core_mod_w-1:0];
        end
    end

    // High half of a word leaves the core mode alone
    a_odd_keeps_mod: assert property (
        @(posedge clk_rom) disable iff (rst)
        (byte_bus.wr && byte_bus.addr[0]) |=> $stable(core_mod)
    ) else $error("core mode changed by an odd-address write");

endmodule

// File: design/dl_top.sv
/*
 * Top of the ROM download path.
 * Host words enter as plain ports, get split into byte writes and
 * are routed to the ROM write port or the configuration registers.
 * Everything runs on clk_rom with an asynchronous, active-high rst.
 */
module dl_top (
    input  logic                          clk_rom,
    input  logic                          rst,

    // Host download channel
    input  logic                          dl_active,
    input  logic [dl_pkg::index_w-1:0]    dl_index,
    input  logic                          dl_wr,
    input  logic [dl_pkg::dl_addr_w-1:0]  dl_addr,
    input  logic [dl_pkg::dl_data_w-1:0]  dl_data,

    // ROM write port
    output logic                          rom_wr,
    output logic [dl_pkg::rom_addr_w-1:0] rom_addr,
    output logic [dl_pkg::byte_w-1:0]     rom_data,
    output logic                          downloading,

    // Configuration
    output logic [dl_pkg::dipsw_w-1:0]    dipsw,
    output logic [dl_pkg::core_mod_w-1:0] core_mod
);

    ioctl_if byte_bus ();

    dwnld_split u_split (
        .clk_rom    ( clk_rom     ),
        .rst        ( rst         ),
        .dl_wr      ( dl_wr       ),
        .dl_addr    ( dl_addr     ),
        .dl_data    ( dl_data     ),
        .dl_index   ( dl_index    ),
        .byte_bus   ( byte_bus    )
    );

    ioctl_router u_router (
        .clk_rom    ( clk_rom     ),
        .rst        ( rst         ),
        .dl_active  ( dl_active   ),
        .dl_index   ( dl_index    ),
        .byte_bus   ( byte_bus    ),
        .rom_wr     ( rom_wr      ),
        .rom_addr   ( rom_addr    ),
        .rom_data   ( rom_data    ),
        .downloading( downloading )
    );

    cfg_store u_cfg (
        .clk_rom    ( clk_rom     ),
        .rst        ( rst         ),
        .byte_bus   ( byte_bus    ),
        .dipsw      ( dipsw       ),
        .core_mod   ( core_mod    )
    );

endmodule

// File: tests/tb_dl_top.sv
/*
 * Testbench for the ROM download path top level.
 * A table of host words is applied one strobe at a time. ROM writes, the
 * downloading flag, the DIP switches and the core mode register are checked
 * against a model built from the download rules. Run it through run.sh.
 */
module tb_dl_top;
    timeunit 1ns;
    timeprecision 1ps;

    // One host word with the download levels it is sent under
    typedef struct packed {
        logic                         active;
        logic [dl_pkg::index_w-1:0]   index;
        logic [dl_pkg::dl_addr_w-1:0] addr;
        logic [dl_pkg::dl_data_w-1:0] data;
        logic                         rnd;
    } stim_t;

    localparam int n_stim        = 10;
    localparam int strobe_to_rom = 2;
    localparam int rom_wait_max  = 8;

    logic                          clk_rom;
    logic                          rst;
    logic                          dl_active;
    logic [dl_pkg::index_w-1:0]    dl_index;
    logic                          dl_wr;
    logic [dl_pkg::dl_addr_w-1:0]  dl_addr;
    logic [dl_pkg::dl_data_w-1:0]  dl_data;
    logic                          rom_wr;
    logic [dl_pkg::rom_addr_w-1:0] rom_addr;
    logic [dl_pkg::byte_w-1:0]     rom_data;
    logic                          downloading;
    logic [dl_pkg::dipsw_w-1:0]    dipsw;
    logic [dl_pkg::core_mod_w-1:0] core_mod;

    stim_t stim [n_stim];
    int    cyc = 0;
    int    rom_count = 0;

    // Model state
    logic [dl_pkg::dipsw_w-1:0]    exp_dipsw;
    logic [dl_pkg::core_mod_w-1:0] exp_core_mod;
    logic                          exp_flag;
    int                            exp_rom_count;

    dl_top dut_i (
        .clk_rom    ( clk_rom     ),
        .rst        ( rst         ),
        .dl_active  ( dl_active   ),
        .dl_index   ( dl_index    ),
        .dl_wr      ( dl_wr       ),
        .dl_addr    ( dl_addr     ),
        .dl_data    ( dl_data     ),
        .rom_wr     ( rom_wr      ),
        .rom_addr   ( rom_addr    ),
        .rom_data   ( rom_data    ),
        .downloading( downloading ),
        .dipsw      ( dipsw       ),
        .core_mod   ( core_mod    )
    );

    always #4 clk_rom = ~clk_rom;

    // Cycle number and ROM write pulses, both read at the falling edge
    always @(posedge clk_rom) begin
        cyc <= cyc + 1;
        if (!rst && rom_wr) begin
            rom_count <= rom_count + 1;
        end
    end

    task automatic stop_failed();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic value_error(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        stop_failed();
    endtask

    task automatic timeout_error(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        stop_failed();
    endtask

    task automatic check_rom(input logic [dl_pkg::rom_addr_w-1:0] addr,
                             input logic [dl_pkg::byte_w-1:0] data);
        if (rom_addr !== addr || rom_data !== data) begin
            value_error($sformatf("ROM write %h <= %h, expected %h <= %h",
                                  rom_addr, rom_data, addr, data));
        end
    endtask

    task automatic check_dipsw(input logic [dl_pkg::dipsw_w-1:0] exp);
        if (dipsw !== exp) begin
            value_error($sformatf("dipsw is %h, expected %h", dipsw, exp));
        end
    endtask

    task automatic check_core_mod(input logic [dl_pkg::core_mod_w-1:0] exp);
        if (core_mod !== exp) begin
            value_error($sformatf("core_mod is %h, expected %h", core_mod, exp));
        end
    endtask

    task automatic check_flag(input logic exp);
        if (downloading !== exp) begin
            value_error($sformatf("downloading is %b, expected %b", downloading, exp));
        end
    endtask

    task automatic check_rom_count(input int exp);
        if (rom_count != exp) begin
            value_error($sformatf("%0d ROM writes seen, expected %0d", rom_count, exp));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_rom);
    endtask

    // Waits for the next rom_wr pulse, returns the cycle it was seen in
    task automatic wait_rom_wr(input int max_cycles, input string what, output int at_cyc);
        int n;
        n = 0;
        @(negedge clk_rom);
        while (rom_wr !== 1'b1 && n < max_cycles) begin
            n++;
            @(negedge clk_rom);
        end
        if (rom_wr !== 1'b1) begin
            timeout_error(what);
        end else begin
            at_cyc = cyc;
        end
    endtask

    // Flag follows the levels exactly one cycle later
    task automatic drive_levels(input logic active, input logic [dl_pkg::index_w-1:0] index);
        logic old_flag;
        old_flag = exp_flag;
        exp_flag = active && (index == 8'd0);
        @(posedge clk_rom);
        dl_active <= active;
        dl_index  <= index;
        @(negedge clk_rom);
        check_flag(old_flag);
        @(negedge clk_rom);
        check_flag(exp_flag);
    endtask

    task automatic host_strobe(input logic [dl_pkg::dl_addr_w-1:0] addr,
                               input logic [dl_pkg::dl_data_w-1:0] data,
                               output int strobe_cyc);
        @(posedge clk_rom);
        dl_addr <= addr;
        dl_data <= data;
        dl_wr   <= 1'b1;
        @(negedge clk_rom);
        strobe_cyc = cyc;
        @(posedge clk_rom);
        dl_wr <= 1'b0;
    endtask

    // Effect of one byte write on ROM port and configuration
    task automatic model_byte(input logic active, input logic [dl_pkg::index_w-1:0] index,
                              input logic [dl_pkg::rom_addr_w-1:0] addr,
                              input logic [dl_pkg::byte_w-1:0] data);
        int sel;
        sel = int'(addr);
        if (active && index == 8'd0) begin
            exp_rom_count++;
        end
        if (index == 8'd254 && sel < 4) begin
            exp_dipsw[sel*8 +: 8] = data;
        end
        if (index == 8'd1 && addr[0] == 1'b0) begin
            exp_core_mod = data[6:0];
        end
    endtask

    task automatic apply_entry(input stim_t s);
        int                            s_cyc;
        int                            lo_cyc;
        int                            hi_cyc;
        logic                          is_rom;
        logic [dl_pkg::rom_addr_w-1:0] lo_addr;
        logic [dl_pkg::rom_addr_w-1:0] hi_addr;
        is_rom  = s.active && s.index == 8'd0;
        lo_addr = {s.addr[dl_pkg::rom_addr_w-1:1], 1'b0};
        hi_addr = {s.addr[dl_pkg::rom_addr_w-1:1], 1'b1};
        if (s.active !== dl_active || s.index !== dl_index) begin
            drive_levels(s.active, s.index);
        end
        host_strobe(s.addr, s.data, s_cyc);
        model_byte(s.active, s.index, lo_addr, s.data[7:0]);
        if (is_rom) begin
            wait_rom_wr(rom_wait_max, "the low byte ROM write", lo_cyc);
            if (lo_cyc != s_cyc + strobe_to_rom) begin
                value_error($sformatf("low byte ROM write %0d cycles after the strobe",
                                      lo_cyc - s_cyc));
            end
            check_rom(lo_addr, s.data[7:0]);
            model_byte(s.active, s.index, hi_addr, s.data[15:8]);
            wait_rom_wr(int'(dl_pkg::dwnld_gap) + rom_wait_max, "the high byte ROM write",
                        hi_cyc);
            if (hi_cyc - lo_cyc != int'(dl_pkg::dwnld_gap)) begin
                value_error($sformatf("high byte ROM write %0d cycles after the low byte",
                                      hi_cyc - lo_cyc));
            end
            check_rom(hi_addr, s.data[15:8]);
            idle_cycles(4);
        end else begin
            // Low byte has landed, high byte still pending
            idle_cycles(strobe_to_rom);
            check_dipsw(exp_dipsw);
            check_core_mod(exp_core_mod);
            model_byte(s.active, s.index, hi_addr, s.data[15:8]);
            idle_cycles(int'(dl_pkg::dwnld_gap) + 4);
        end
        check_rom_count(exp_rom_count);
        check_dipsw(exp_dipsw);
        check_core_mod(exp_core_mod);
        check_flag(exp_flag);
    endtask

    // Active, index, host address, word, random word
    task automatic fill_table();
        stim[0] = '{1'b1, 8'd0,   27'h0000100, 16'ha55a, 1'b0};
        stim[1] = '{1'b1, 8'd0,   27'h6abcde4, 16'h0000, 1'b1};
        stim[2] = '{1'b1, 8'd0,   27'h0000033, 16'h0000, 1'b1};
        stim[3] = '{1'b0, 8'd0,   27'h0000040, 16'h0000, 1'b1};
        stim[4] = '{1'b0, 8'd0,   27'h0000042, 16'hc3d2, 1'b0};
        stim[5] = '{1'b1, 8'd254, 27'h0000000, 16'h3412, 1'b0};
        stim[6] = '{1'b1, 8'd254, 27'h0000002, 16'h7856, 1'b0};
        stim[7] = '{1'b1, 8'd254, 27'h0000004, 16'hbeef, 1'b0};
        stim[8] = '{1'b1, 8'd1,   27'h0000000, 16'h2a55, 1'b0};
        stim[9] = '{1'b1, 8'd1,   27'h0000002, 16'h0f83, 1'b0};
    endtask

    initial begin
        logic [31:0] rnd_word;
        clk_rom   = 1'b0;
        rst       = 1'b1;
        dl_active = 1'b0;
        dl_index  = '0;
        dl_wr     = 1'b0;
        dl_addr   = '0;
        dl_data   = '0;
        exp_dipsw     = {dl_pkg::dipsw_w{1'b1}};
        exp_core_mod  = 7'd1;
        exp_flag      = 1'b0;
        exp_rom_count = 0;
        void'($urandom(32'h687b));
        fill_table();
        for (int i = 0; i < n_stim; i++) begin
            if (stim[i].rnd) begin
                rnd_word = $urandom();
                stim[i].data = rnd_word[15:0];
            end
        end

        repeat (2) @(posedge clk_rom);
        rst <= 1'b0;
        idle_cycles(2);

        // Reset values
        check_dipsw(exp_dipsw);
        check_core_mod(exp_core_mod);
        check_flag(1'b0);
        check_rom_count(0);
        if (rom_wr !== 1'b0) begin
            value_error("rom_wr is high after reset");
        end

        for (int i = 0; i < n_stim; i++) begin
            apply_entry(stim[i]);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: sources.f
design/dl_pkg.sv
design/ioctl_if.sv
design/dwnld_split.sv
design/ioctl_router.sv
design/cfg_store.sv
design/dl_top.sv
tests/tb_dl_top.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# Exits non-zero unless the simulation prints its pass line.
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_dl_top -o sim_dl_top &&
./obj_dir/sim_dl_top | tee /dev/stderr | grep -q -F "*** TEST PASSED ***" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
